//--- design/fbd_cfg.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 640x480 at 60 Hz needs a 25.175 MHz pixel clock
// buffer fixed at 160x120, drawn top-left without scaling
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef FBD_CFG_SVH
`define FBD_CFG_SVH

// framebuffer geometry
`define FB_WIDTH    160
`define FB_HEIGHT   120
`define FB_PIXELS   (`FB_WIDTH * `FB_HEIGHT)  // 19200 entries

// colour lookup
`define PAL_DEPTH   16      // palette entries
`define CHAN_W      4       // bits per colour channel
`define BG_COLR     12'h137 // outside the buffer, inside active video

// horizontal timing in pixels
`define H_ACTIVE    640
`define H_FRONT     16
`define H_SYNC      96
`define H_BACK      48
`define H_TOTAL     (`H_ACTIVE + `H_FRONT + `H_SYNC + `H_BACK)  // 800

// vertical timing in lines
`define V_ACTIVE    480
`define V_FRONT     10
`define V_SYNC      2
`define V_BACK      33
`define V_TOTAL     (`V_ACTIVE + `V_FRONT + `V_SYNC + `V_BACK)  // 525

// screen coordinate width, enough for 800 and 525
`define COORD_W     10

`endif

//--- design/fbd_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// widths follow fbd_cfg.svh, no other settings here
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "fbd_cfg.svh"

package fbd_pkg;

    // colour index, one framebuffer entry
    // also the palette address
    typedef logic [$clog2(`PAL_DEPTH)-1:0] cidx_t;

    // rgb colour, red in the top nibble
    // then green, then blue
    typedef logic [3*`CHAN_W-1:0] colr_t;

    // linear framebuffer address, row major
    // 15 bits for 19200 entries
    typedef logic [$clog2(`FB_PIXELS)-1:0] fb_addr_t;

    // unsigned screen coordinate
    // covers blanking too, up to 799 and 524
    typedef logic [`COORD_W-1:0] coord_t;

endpackage

//--- design/display_timing.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// syncs active low, all outputs registered
// counters sit at 0,0 during reset
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

`include "fbd_cfg.svh"

module display_timing (
    input  logic            clk_pix,
    input  logic            rst,
    output fbd_pkg::coord_t sx,     // pixel within line
    output fbd_pkg::coord_t sy,     // line within frame
    output logic            de,     // active video
    output logic            hsync,
    output logic            vsync,
    output logic            frame   // one cycle at 0,0
);
    import fbd_pkg::*;

    // horizontal landmarks
    localparam coord_t HA_END   = coord_t'(`H_ACTIVE);
    localparam coord_t HS_STA   = coord_t'(`H_ACTIVE + `H_FRONT);  // 656
    localparam coord_t HS_END   = coord_t'(`H_ACTIVE + `H_FRONT + `H_SYNC - 1);  // 751
    localparam coord_t LINE_END = coord_t'(`H_TOTAL - 1);

    // vertical landmarks
    localparam coord_t VA_END    = coord_t'(`V_ACTIVE);
    localparam coord_t VS_STA    = coord_t'(`V_ACTIVE + `V_FRONT);  // 490
    localparam coord_t VS_END    = coord_t'(`V_ACTIVE + `V_FRONT + `V_SYNC - 1);  // 491
    localparam coord_t FRAME_END = coord_t'(`V_TOTAL - 1);

    coord_t sx_nxt;
    coord_t sy_nxt;

    // next position, reset parks it at the origin
    always_comb begin
        if (rst) begin
            sx_nxt = '0;
            sy_nxt = '0;
        end else if (sx == LINE_END) begin
            sx_nxt = '0;  // wrap line
            sy_nxt = (sy == FRAME_END) ? '0 : sy + 1'b1;
        end else begin
            sx_nxt = sx + 1'b1;
            sy_nxt = sy;
        end
    end

    // flags decoded from the next position
    // so they land in the same cycle as sx and sy
    always_ff @(posedge clk_pix) begin
        sx    <= sx_nxt;
        sy    <= sy_nxt;
        de    <= (sx_nxt < HA_END) && (sy_nxt < VA_END);
        hsync <= !((sx_nxt >= HS_STA) && (sx_nxt <= HS_END));  // low in pulse
        vsync <= !((sy_nxt >= VS_STA) && (sy_nxt <= VS_END));
        frame <= (sx_nxt == '0) && (sy_nxt == '0);
    end

endmodule

//--- design/fb_scan_ctrl.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// read address is combinational from sx,sy
// flags come out two cycles late to meet the palette colour
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

`include "fbd_cfg.svh"

module fb_scan_ctrl (
    input  logic              clk_pix,
    input  logic              rst,
    input  fbd_pkg::coord_t   sx,
    input  fbd_pkg::coord_t   sy,
    input  logic              de,
    input  logic              hsync,
    input  logic              vsync,
    output fbd_pkg::fb_addr_t fb_rd_addr,   // to framebuffer ram
    output logic              paint_de,     // delayed 2
    output logic              paint_area,   // delayed 2
    output logic              paint_hsync,  // delayed 2
    output logic              paint_vsync   // delayed 2
);
    import fbd_pkg::*;

    localparam coord_t   FB_W        = coord_t'(`FB_WIDTH);
    localparam coord_t   FB_H        = coord_t'(`FB_HEIGHT);
    localparam coord_t   FB_LAST_ROW = coord_t'(`FB_HEIGHT - 1);
    localparam coord_t   LINE_END    = coord_t'(`H_TOTAL - 1);
    localparam coord_t   FRAME_END   = coord_t'(`V_TOTAL - 1);
    localparam fb_addr_t ROW_STEP    = fb_addr_t'(`FB_WIDTH);

    logic     area;       // position inside the buffer
    fb_addr_t line_base;  // sy*160 while sy is a buffer row
    fb_addr_t addr_last;  // held address outside the area

    logic [1:0] de_sr;
    logic [1:0] area_sr;
    logic [1:0] hs_sr;
    logic [1:0] vs_sr;

    always_comb begin
        area = (sx < FB_W) && (sy < FB_H);
        fb_rd_addr = area ? line_base + fb_addr_t'(sx) : addr_last;
    end

    // row base, stepped at the end of each line instead of a multiply
    always_ff @(posedge clk_pix) begin
        if (rst) begin
            line_base <= '0;
            addr_last <= '0;
        end else begin
            addr_last <= fb_rd_addr;
            if (sx == LINE_END) begin
                if (sy == FRAME_END) begin
                    line_base <= '0;  // back to row 0 for next frame
                end else if (sy < FB_LAST_ROW) begin
                    line_base <= line_base + ROW_STEP;
                end
                // below the buffer the base just stays put
            end
        end
    end

    // two stages: fb ram read, then palette read
    always_ff @(posedge clk_pix) begin
        if (rst) begin
            de_sr   <= '0;
            area_sr <= '0;
            hs_sr   <= '1;  // syncs idle high
            vs_sr   <= '1;
        end else begin
            de_sr   <= {de_sr[0], de};
            area_sr <= {area_sr[0], area};
            hs_sr   <= {hs_sr[0], hsync};
            vs_sr   <= {vs_sr[0], vsync};
        end
    end

    always_comb begin
        paint_de    = de_sr[1];
        paint_area  = area_sr[1];
        paint_hsync = hs_sr[1];
        paint_vsync = vs_sr[1];
    end

endmodule

//--- design/sdp_ram.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// one clock, registered read, no init contents
// read of a just-written address one cycle later sees new data
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module sdp_ram #(
    parameter type data_t = logic [7:0],   // payload per entry
    parameter int  DEPTH  = 256,
    parameter int  ADDRW  = $clog2(DEPTH)
) (
    input  logic             clk_pix,
    input  logic             we,
    input  logic [ADDRW-1:0] wr_addr,
    input  data_t            wr_data,
    input  logic [ADDRW-1:0] rd_addr,
    output data_t            rd_data
);

    // block ram array, no reset so it infers
    data_t mem [DEPTH];

    always_ff @(posedge clk_pix) begin
        if (we) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // read port, old data on a same-cycle collision
    always_ff @(posedge clk_pix) begin
        rd_data <= mem[rd_addr];
    end

endmodule

//--- design/pixel_output.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// final register stage before the pins
// reset gives black with both syncs high
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

`include "fbd_cfg.svh"

module pixel_output (
    input  logic           clk_pix,
    input  logic           rst,
    input  fbd_pkg::colr_t colr,         // palette colour
    input  logic           paint_de,
    input  logic           paint_area,
    input  logic           paint_hsync,
    input  logic           paint_vsync,
    output logic           vga_hsync,
    output logic           vga_vsync,
    output logic [3:0]     vga_r,
    output logic [3:0]     vga_g,
    output logic [3:0]     vga_b
);
    import fbd_pkg::*;

    localparam colr_t BG = colr_t'(`BG_COLR);

    colr_t out_colr;

    // blanking wins, then buffer area, else background
    always_comb begin
        if (!paint_de) begin
            out_colr = '0;
        end else if (paint_area) begin
            out_colr = colr;
        end else begin
            out_colr = BG;
        end
    end

    always_ff @(posedge clk_pix) begin
        if (rst) begin
            vga_hsync <= 1'b1;
            vga_vsync <= 1'b1;
            vga_r     <= '0;
            vga_g     <= '0;
            vga_b     <= '0;
        end else begin
            vga_hsync <= paint_hsync;
            vga_vsync <= paint_vsync;
            {vga_r, vga_g, vga_b} <= out_colr;  // red high
        end
    end

endmodule

//--- design/framebuffer_display.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// pixel clock comes in ready, no pll here
// raster to pins is 3 cycles, writes need no handshake
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

`include "fbd_cfg.svh"

module framebuffer_display (
    input  logic              clk_pix,
    input  logic              rst,
    // framebuffer write port
    input  logic              fb_we,
    input  fbd_pkg::fb_addr_t fb_wr_addr,
    input  fbd_pkg::cidx_t    fb_wr_cidx,
    // palette write port
    input  logic              pal_we,
    input  fbd_pkg::cidx_t    pal_wr_idx,
    input  fbd_pkg::colr_t    pal_wr_colr,
    // vga pins
    output logic              vga_hsync,
    output logic              vga_vsync,
    output logic [3:0]        vga_r,
    output logic [3:0]        vga_g,
    output logic [3:0]        vga_b
);
    import fbd_pkg::*;

    coord_t   sx;
    coord_t   sy;
    logic     de;
    logic     hsync;
    logic     vsync;
    fb_addr_t fb_rd_addr;
    cidx_t    fb_rd_cidx;   // index, one cycle after address
    colr_t    pal_colr;     // colour, two cycles after address
    logic     paint_de;
    logic     paint_area;
    logic     paint_hsync;
    logic     paint_vsync;

    display_timing display_timing_inst (
        .clk_pix (clk_pix),
        .rst     (rst),
        .sx      (sx),
        .sy      (sy),
        .de      (de),
        .hsync   (hsync),
        .vsync   (vsync),
        .frame   ()           // frame strobe not needed here
    );

    fb_scan_ctrl fb_scan_ctrl_inst (
        .clk_pix     (clk_pix),
        .rst         (rst),
        .sx          (sx),
        .sy          (sy),
        .de          (de),
        .hsync       (hsync),
        .vsync       (vsync),
        .fb_rd_addr  (fb_rd_addr),
        .paint_de    (paint_de),
        .paint_area  (paint_area),
        .paint_hsync (paint_hsync),
        .paint_vsync (paint_vsync)
    );

    // framebuffer, 160x120 colour indices
    sdp_ram #(
        .data_t (cidx_t),
        .DEPTH  (`FB_PIXELS),
        .ADDRW  ($bits(fb_addr_t))
    ) fb_ram_inst (
        .clk_pix (clk_pix),
        .we      (fb_we),
        .wr_addr (fb_wr_addr),
        .wr_data (fb_wr_cidx),
        .rd_addr (fb_rd_addr),
        .rd_data (fb_rd_cidx)
    );

    // palette, index in, colour out
    sdp_ram #(
        .data_t (colr_t),
        .DEPTH  (`PAL_DEPTH),
        .ADDRW  ($bits(cidx_t))
    ) pal_ram_inst (
        .clk_pix (clk_pix),
        .we      (pal_we),
        .wr_addr (pal_wr_idx),
        .wr_data (pal_wr_colr),
        .rd_addr (fb_rd_cidx),
        .rd_data (pal_colr)
    );

    pixel_output pixel_output_inst (
        .clk_pix     (clk_pix),
        .rst         (rst),
        .colr        (pal_colr),
        .paint_de    (paint_de),
        .paint_area  (paint_area),
        .paint_hsync (paint_hsync),
        .paint_vsync (paint_vsync),
        .vga_hsync   (vga_hsync),
        .vga_vsync   (vga_vsync),
        .vga_r       (vga_r),
        .vga_g       (vga_g),
        .vga_b       (vga_b)
    );

endmodule

//--- tests/tb_clock.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 4 ns pixel clock, reset high for 5 rising edges
// reset drops 1 ns after an edge
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module tb_clock (
    output logic clk_pix,
    output logic rst
);

    initial begin
        clk_pix = 1'b0;
        forever #2 clk_pix = ~clk_pix;  // half period
    end

    initial begin
        rst = 1'b1;
        repeat (5) @(posedge clk_pix);
        #1 rst = 1'b0;  // same skew as the other inputs
    end

endmodule

//--- tests/tb_framebuffer_display.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// data file path is relative to the project root
// checks inside one frame must come in raster order
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

`include "fbd_cfg.svh"

module tb_framebuffer_display;
    import fbd_pkg::*;

    localparam int LINE_CYC  = `H_TOTAL;
    localparam int FRAME_CYC = `H_TOTAL * `V_TOTAL;
    localparam int VBL_CNT   = `H_TOTAL * `V_ACTIVE;  // counters at (0,480)
    localparam int HS_LO     = `H_ACTIVE + `H_FRONT;  // first low column
    localparam int HS_HI     = HS_LO + `H_SYNC - 1;
    localparam int VS_LO     = `V_ACTIVE + `V_FRONT;
    localparam int VS_HI     = VS_LO + `V_SYNC - 1;
    localparam int LATENCY   = 3;
    localparam int MAX_REC   = 200;
    localparam int SWEEP     = 7;  // test number of the raster monitor

    logic       clk_pix;
    logic       rst;
    logic       fb_we;
    fb_addr_t   fb_wr_addr;
    cidx_t      fb_wr_cidx;
    logic       pal_we;
    cidx_t      pal_wr_idx;
    colr_t      pal_wr_colr;
    logic       vga_hsync;
    logic       vga_vsync;
    logic [3:0] vga_r;
    logic [3:0] vga_g;
    logic [3:0] vga_b;

    logic [15:0] recs [0:1023];  // five words per record
    int unsigned run_cnt   = 0;  // counter position in cycles since reset release
    int unsigned cyc       = 0;
    int unsigned cyc_limit = 0;
    int          chk_cnt [0:15];
    int          err_cnt [0:15];
    int          other_err = 0;

    tb_clock clock_inst (
        .clk_pix (clk_pix),
        .rst     (rst)
    );

    framebuffer_display framebuffer_display_inst (
        .clk_pix     (clk_pix),
        .rst         (rst),
        .fb_we       (fb_we),
        .fb_wr_addr  (fb_wr_addr),
        .fb_wr_cidx  (fb_wr_cidx),
        .pal_we      (pal_we),
        .pal_wr_idx  (pal_wr_idx),
        .pal_wr_colr (pal_wr_colr),
        .vga_hsync   (vga_hsync),
        .vga_vsync   (vga_vsync),
        .vga_r       (vga_r),
        .vga_g       (vga_g),
        .vga_b       (vga_b)
    );

    always @(posedge clk_pix) begin
        run_cnt <= rst ? 0 : run_cnt + 1;
        cyc     <= cyc + 1;
        if (cyc_limit != 0 && cyc >= cyc_limit) begin
            $display("timeout: records not finished within %0d cycles", cyc_limit);
            $display("Test failed");
            $finish;
        end
    end

    function automatic string test_name(input int tnum);
        case (tnum)
            1:       return "reset_fill";
            2:       return "fb_pixels";
            3:       return "background";
            4:       return "blank_sync";
            5:       return "palette_rewrite";
            6:       return "fb_rewrite";
            SWEEP:   return "raster_sweep";
            default: return "unnamed";
        endcase
    endfunction

    function automatic int field(input int rec, input int k);
        return int'(recs[10'(rec * 5 + k)]);
    endfunction

    // raster position now on the pins at latency 3
    function automatic int out_pos();
        return int'((run_cnt - LATENCY) % FRAME_CYC);
    endfunction

    task automatic check_value(input int tnum, input logic [11:0] exp_v,
                               input logic [11:0] act_v);
        chk_cnt[tnum[3:0]]++;
        if (act_v !== exp_v) begin
            err_cnt[tnum[3:0]]++;
            $display("ERR %s cycle %0d expected %03h actual %03h",
                     test_name(tnum), run_cnt, exp_v, act_v);
        end
    endtask

    task automatic report_test(input int tnum);
        $display("test %0d %s checks %0d errors %0d", tnum, test_name(tnum),
                 chk_cnt[tnum[3:0]], err_cnt[tnum[3:0]]);
    endtask

    task automatic write_fb(input int x, input int y, input int cidx);
        @(posedge clk_pix);
        #1;
        fb_we      = 1'b1;
        fb_wr_addr = fb_addr_t'(y * `FB_WIDTH + x);  // row major
        fb_wr_cidx = cidx_t'(cidx);
        @(posedge clk_pix);
        #1;
        fb_we = 1'b0;
    endtask

    task automatic write_pal(input int idx, input int colr);
        @(posedge clk_pix);
        #1;
        pal_we      = 1'b1;
        pal_wr_idx  = cidx_t'(idx);
        pal_wr_colr = colr_t'(colr);
        @(posedge clk_pix);
        #1;
        pal_we = 1'b0;
    endtask

    // next time the counters enter vertical blanking
    task automatic wait_vblank();
        do begin
            @(posedge clk_pix);
            #1;
        end while (run_cnt % FRAME_CYC != VBL_CNT);
    endtask

    // next negedge where (x,y) is on the pins
    task automatic wait_for_output(input int x, input int y);
        int target;
        target = y * LINE_CYC + x;
        do begin
            @(negedge clk_pix);
        end while (!(run_cnt >= LATENCY && out_pos() == target));
    endtask

    // idle pins until the pipeline fills then syncs and blanking every cycle
    task automatic raster_monitor();
        int   ox;
        int   oy;
        logic hs_exp;
        logic vs_exp;
        logic fill_done;
        fill_done = 1'b0;
        forever begin
            @(negedge clk_pix);
            if (rst || run_cnt < LATENCY) begin
                check_value(1, 12'h003, {10'd0, vga_hsync, vga_vsync});
                check_value(1, 12'h000, {vga_r, vga_g, vga_b});
            end else begin
                if (!fill_done) begin
                    report_test(1);
                    fill_done = 1'b1;
                end
                ox = out_pos() % LINE_CYC;
                oy = out_pos() / LINE_CYC;
                hs_exp = !(ox >= HS_LO && ox <= HS_HI);
                vs_exp = !(oy >= VS_LO && oy <= VS_HI);
                check_value(SWEEP, {10'd0, hs_exp, vs_exp}, {10'd0, vga_hsync, vga_vsync});
                if (ox >= `H_ACTIVE || oy >= `V_ACTIVE) begin
                    check_value(SWEEP, 12'h000, {vga_r, vga_g, vga_b});  // blanking
                end
            end
        end
    endtask

    initial begin
        int op;
        int rx;
        int ry;
        int rval;
        int cur_test;
        int frames;
        int prev_pos;
        int tot_chk;
        int tot_err;
        fb_we       = 1'b0;
        fb_wr_addr  = '0;
        fb_wr_cidx  = '0;
        pal_we      = 1'b0;
        pal_wr_idx  = '0;
        pal_wr_colr = '0;
        $readmemh("tests/pixel_tests.mem", recs);

        // frame budget from waits and raster wraps between checks
        frames   = 0;
        prev_pos = -1;
        for (int i = 0; i < MAX_REC && field(i, 0) != 0; i++) begin
            op = field(i, 0);
            if (op == 3) begin
                frames++;
                prev_pos = VBL_CNT;
            end else if (op >= 4) begin
                if (field(i, 2) * LINE_CYC + field(i, 1) <= prev_pos) frames++;
                prev_pos = field(i, 2) * LINE_CYC + field(i, 1);
            end
        end
        cyc_limit = (frames + 2) * FRAME_CYC;
        if (field(0, 0) == 0) begin
            $display("stimulus file tests/pixel_tests.mem gave no records");
            other_err++;
        end

        fork
            raster_monitor();
        join_none

        cur_test = 0;
        for (int i = 0; i < MAX_REC; i++) begin
            op = field(i, 0);
            if (op == 0) break;  // end record
            rx   = field(i, 1);
            ry   = field(i, 2);
            rval = field(i, 3);
            if (field(i, 4) != cur_test) begin
                if (cur_test != 0) report_test(cur_test);
                cur_test = field(i, 4);
            end
            case (op)
                1: write_fb(rx, ry, rval);
                2: write_pal(rx, rval);
                3: wait_vblank();
                4: begin
                    wait_for_output(rx, ry);
                    check_value(cur_test, 12'(rval), {vga_r, vga_g, vga_b});
                end
                5: begin
                    wait_for_output(rx, ry);
                    check_value(cur_test, 12'(rval), {10'd0, vga_hsync, vga_vsync});
                end
                default: begin
                    $display("record %0d has an unknown opcode %0d", i, op);
                    other_err++;
                end
            endcase
        end
        if (cur_test != 0) report_test(cur_test);
        report_test(SWEEP);

        tot_chk = 0;
        tot_err = other_err;
        for (int i = 1; i < 16; i++) begin
            tot_chk += chk_cnt[i[3:0]];
            tot_err += err_cnt[i[3:0]];
        end
        $display("totals: %0d checks, %0d errors", tot_chk, tot_err);
        if (tot_err == 0 && tot_chk > 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- tests/pixel_tests.mem
// op x y value test, all hex, one record per line
// op 1 fb write, 2 palette write, 3 wait vblank, 4 check colour, 5 check {hs,vs}, 0 end
4 0a0 000 137 3  // (160,0) frame 0
4 000 078 137 3  // (0,120)
4 27f 1df 137 3  // (639,479)
4 285 1df 000 4  // (645,479) right border black
4 000 1e5 000 4  // (0,485)
5 28f 1e9 003 4  // (655,489)
5 290 1e9 001 4  // (656,489) hsync starts
5 2ef 1e9 001 4  // (751,489)
5 2f0 1e9 003 4  // (752,489)
5 000 1ea 002 4  // (0,490) vsync low
5 2bc 1eb 000 4  // (700,491) both low
5 000 1ec 003 4  // (0,492)
// still in vblank of frame 0, load palette then pixels
2 001 000 f00 2
2 002 000 0f0 2
2 003 000 00f 2
2 004 000 ff0 2
1 000 000 001 2
1 005 000 001 2
1 04d 035 003 2  // (77,53)
1 064 064 004 2  // (100,100)
1 09f 077 002 2  // (159,119)
4 000 000 f00 2
4 005 000 f00 2
4 04d 035 00f 2
4 064 064 ff0 2
4 09f 077 0f0 2
3 000 000 000 5  // entry 1 turns cyan
2 001 000 0ff 5
4 000 000 0ff 5
4 005 000 0ff 5
4 04d 035 00f 5
4 09f 077 0f0 5
3 000 000 000 6  // (77,53) moves to index 4
1 04d 035 004 6
4 000 000 0ff 6
4 04d 035 ff0 6
4 09f 077 0f0 6
0 000 000 000 0

//--- compile.f
+incdir+design
design/fbd_pkg.sv
design/display_timing.sv
design/fb_scan_ctrl.sv
design/sdp_ram.sv
design/pixel_output.sv
design/framebuffer_display.sv
tests/tb_clock.sv
tests/tb_framebuffer_display.sv

//--- run_sim.sh
#!/bin/sh
# run from the project root; exit status follows the testbench result
verilator --binary --timing -f compile.f --top-module tb_framebuffer_display -o sim_tb \
    && ./obj_dir/sim_tb | tee /dev/stderr | grep -qx "Test passed" \
    && echo "simulation ok" && exit 0 \
    || { echo "simulation not ok"; exit 1; }
